//--- command_decoder.sv
`timescale 1ns/1ps
`include "motion_consts.svh"

module command_decoder import motion_pkg::*; (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       word_received,
  input  word_t      word_data,
  input  count_t     enc_count,
  input  logic       buffer_dtr,
  output word_t      reply_data,
  output logic       move_push,
  output count_t     move_duration,
  output count_t     move_increment,
  output count_t     move_incr_incr,
  output logic       move_dir,
  output div_t       clock_divisor,
  output logic       enable,
  output logic [2:0] microsteps,
  output logic [7:0] current
);

  msg_state_t state;
  cmd_t       hdr_cmd;
  count_t     enc_snap;      // Position at move start
  logic       snap_pending;  // Take the snapshot next cycle

  assign hdr_cmd = word_data[63:56];

  // Message FSM, config registers and reply
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state         <= ST_HEADER;
      reply_data    <= '0;
      move_push     <= 1'b0;
      snap_pending  <= 1'b0;
      clock_divisor <= `DEFAULT_CLK_DIVISOR;
      enable        <= 1'b0;
      microsteps    <= 3'd2;
      current       <= 8'd140;
    end else begin
      move_push    <= 1'b0;
      snap_pending <= 1'b0;
      if (word_received) begin
        reply_data <= '0;  // Most replies are empty
        case (state)
          ST_HEADER: begin
            case (hdr_cmd)
              `CMD_COORDINATED_STEP: begin
                state        <= ST_DURATION;
                snap_pending <= 1'b1;
              end
              `CMD_MOTOR_ENABLE: enable <= word_data[0];
              `CMD_CLK_DIVISOR:  clock_divisor <= word_data[7:0];
              `CMD_MOTORCONFIG: begin
                current    <= word_data[15:8];
                microsteps <= word_data[2:0];
              end
              `CMD_API_VERSION: begin
                reply_data <= {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
              end
              default: ;  // Unknown command ignored
            endcase
          end
          ST_DURATION: begin
            state      <= ST_INCREMENT;
            reply_data <= enc_snap;  // Goes out with the increment word
          end
          ST_INCREMENT: state <= ST_INCR_INCR;
          ST_INCR_INCR: begin
            state     <= ST_HEADER;
            move_push <= buffer_dtr;  // Full buffer drops the move
          end
          default: state <= ST_HEADER;
        endcase
      end
    end
  end

  // Move record and encoder snapshot
  always_ff @(posedge CLK) begin
    if (snap_pending) begin
      enc_snap <= enc_count;
    end
    if (word_received) begin
      case (state)
        ST_HEADER: begin
          if (hdr_cmd == `CMD_COORDINATED_STEP) begin
            move_dir <= word_data[0];
          end
        end
        ST_DURATION:  move_duration  <= word_data;
        ST_INCREMENT: move_increment <= word_data;
        ST_INCR_INCR: move_incr_incr <= word_data;
        default: ;
      endcase
    end
  end

  // Pushes come only from the last word of a move
  a_push_on_last_word: assert property (@(posedge CLK) disable iff (!resetn)
    move_push |-> ($past(word_received && state == ST_INCR_INCR) && state == ST_HEADER))
    else $error("move_push outside the last move word");

endmodule

//--- motion_consts.svh
`ifndef MOTION_CONSTS_SVH
`define MOTION_CONSTS_SVH

// Command bytes, found in the top byte of a header word
`define CMD_COORDINATED_STEP 8'h01
`define CMD_MOTOR_ENABLE     8'h0a
`define CMD_CLK_DIVISOR      8'h0b
`define CMD_MOTORCONFIG      8'h10
`define CMD_API_VERSION      8'hfe

// API version returned to the host
`define VERSION_MAJOR 8'd0
`define VERSION_MINOR 8'd3
`define VERSION_PATCH 8'd1

// Move buffer depth
`define MOVE_BUFFER_BITS 2
`define MOVE_BUFFER_SIZE (1 << `MOVE_BUFFER_BITS)

// One full step of the DDA accumulator
`define STEP_THRESHOLD 64'h0000_0001_0000_0000

// Tick every 41 clocks out of reset
`define DEFAULT_CLK_DIVISOR 8'd40

`endif

//--- motion_pkg.sv
`include "motion_consts.svh"

package motion_pkg;

  // One SPI word, little endian on the host side
  typedef logic [63:0] word_t;

  // Header command byte
  typedef logic [7:0] cmd_t;

  // Position, accumulator and increments
  typedef logic signed [63:0] count_t;

  // Move buffer pointer
  typedef logic [`MOVE_BUFFER_BITS-1:0] buf_idx_t;

  // Tick divisor
  typedef logic [7:0] div_t;

  // Word position inside a message
  typedef enum logic [1:0] {
    ST_HEADER,     // Next word is a command header
    ST_DURATION,   // Move word 1
    ST_INCREMENT,  // Move word 2
    ST_INCR_INCR   // Move word 3, last one
  } msg_state_t;

endpackage

//--- motion_top.sv
`timescale 1ns/1ps

module motion_top import motion_pkg::*; (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       sck,
  input  logic       cs,
  input  logic       copi,
  input  logic       enc_a,
  input  logic       enc_b,
  input  logic       halt_n,
  output logic       cipo,
  output logic       step,
  output logic       dir,
  output logic       enable,
  output logic [2:0] microsteps,
  output logic [7:0] current,
  output logic       buffer_dtr,
  output logic       move_done,
  output logic       enc_fault
);

  logic   word_received;
  word_t  word_data;
  word_t  reply_data;
  logic   move_push;   // Finished move record
  count_t move_duration;
  count_t move_increment;
  count_t move_incr_incr;
  logic   move_dir;
  div_t   clock_divisor;
  count_t enc_count;

  // Host link
  spi_word spi_word_i (
    .CLK           (CLK),
    .resetn        (resetn),
    .sck           (sck),
    .cs            (cs),
    .copi          (copi),
    .reply_data    (reply_data),
    .cipo          (cipo),
    .word_received (word_received),
    .word_data     (word_data)
  );

  command_decoder command_decoder_i (
    .CLK            (CLK),
    .resetn         (resetn),
    .word_received  (word_received),
    .word_data      (word_data),
    .enc_count      (enc_count),
    .buffer_dtr     (buffer_dtr),
    .reply_data     (reply_data),
    .move_push      (move_push),
    .move_duration  (move_duration),
    .move_increment (move_increment),
    .move_incr_incr (move_incr_incr),
    .move_dir       (move_dir),
    .clock_divisor  (clock_divisor),
    .enable         (enable),
    .microsteps     (microsteps),
    .current        (current)
  );

  step_generator step_generator_i (
    .CLK            (CLK),
    .resetn         (resetn),
    .halt_n         (halt_n),
    .move_push      (move_push),
    .move_duration  (move_duration),
    .move_increment (move_increment),
    .move_incr_incr (move_incr_incr),
    .move_dir       (move_dir),
    .clock_divisor  (clock_divisor),
    .step           (step),
    .dir            (dir),
    .buffer_dtr     (buffer_dtr),
    .move_done      (move_done)
  );

  // Position feedback
  quad_encoder quad_encoder_i (
    .CLK       (CLK),
    .resetn    (resetn),
    .enc_a     (enc_a),
    .enc_b     (enc_b),
    .enc_count (enc_count),
    .enc_fault (enc_fault)
  );

endmodule

//--- quad_encoder.sv
`timescale 1ns/1ps

module quad_encoder import motion_pkg::*; (
  input  logic   CLK,
  input  logic   resetn,
  input  logic   enc_a,
  input  logic   enc_b,
  output count_t enc_count,
  output logic   enc_fault
);

  logic [2:0] a_q;    // Sync stages plus previous sample
  logic [2:0] b_q;
  logic       a_chg;
  logic       b_chg;
  logic       count_up;

  // Two flop synchronizers with one history stage
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      a_q <= {a_q[1:0], enc_a};
      b_q <= {b_q[1:0], enc_b};
    end
  end

  assign a_chg = a_q[1] ^ a_q[2];
  assign b_chg = b_q[1] ^ b_q[2];

  // A leading gives 00 10 11 01
  // When A moves, up if A and B now differ
  // When B moves, up if A and B now match
  assign count_up = a_chg ? (a_q[1] ^ b_q[1]) : ~(a_q[1] ^ b_q[1]);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      enc_count <= '0;
      enc_fault <= 1'b0;
    end else if (a_chg && b_chg) begin
      enc_fault <= 1'b1;  // Illegal Gray step, sticky until reset
    end else if (a_chg || b_chg) begin
      if (count_up) begin
        enc_count <= enc_count + 64'sd1;
      end else begin
        enc_count <= enc_count - 64'sd1;
      end
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the motion controller testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_motion -f src.f \
  -o sim_motion > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_motion > sim.log 2>&1 ; cat sim.log
grep -q "All tests passed" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- spi_word.sv
`timescale 1ns/1ps

module spi_word import motion_pkg::*; (
  input  logic  CLK,
  input  logic  resetn,
  input  logic  sck,
  input  logic  cs,
  input  logic  copi,
  input  word_t reply_data,
  output logic  cipo,
  output logic  word_received,
  output word_t word_data
);

  logic [2:0] sck_q;   // Two sync stages, third for edge detect
  logic [2:0] cs_q;
  logic [1:0] copi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_fall;
  logic       cs_s;    // Synchronized chip select
  logic [5:0] bit_cnt; // Wraps after 64 bits
  logic       rx_full; // Last bit just shifted in
  word_t      rx_shift;
  word_t      tx_shift;

  // Pin synchronizers
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q  <= '0;
      cs_q   <= '1;  // Idle deselected, no false falling edge
      copi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs};
      copi_q <= {copi_q[0], copi};
    end
  end

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign cs_fall  = ~cs_q[1] & cs_q[2];
  assign cs_s     = cs_q[1];

  // Bit counter and word strobe
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt       <= '0;
      rx_full       <= 1'b0;
      word_received <= 1'b0;
    end else begin
      rx_full       <= 1'b0;
      word_received <= rx_full;  // One extra stage after the last bit
      if (cs_s) begin
        bit_cnt <= '0;           // Deselect realigns the frame
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 6'd1;
        rx_full <= (bit_cnt == 6'd63);
      end
    end
  end

  // Receive path, MSB first
  always_ff @(posedge CLK) begin
    if (!cs_s && sck_rise) begin
      rx_shift <= {rx_shift[62:0], copi_q[1]};
    end
    if (rx_full) begin
      word_data <= rx_shift;  // Held until the next word
    end
  end

  // Reply loads on select, shifts on each falling sck
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tx_shift <= '0;
    end else if (cs_fall) begin
      tx_shift <= reply_data;
    end else if (!cs_s && sck_fall) begin
      tx_shift <= {tx_shift[62:0], 1'b0};
    end
  end

  assign cipo = tx_shift[63];

  // A word completes only inside a selected frame
  a_word_in_frame: assert property (@(posedge CLK) disable iff (!resetn)
    word_received |-> !cs_s)
    else $error("word_received while cs high");

endmodule

//--- src.f
+incdir+.
motion_pkg.sv
spi_word.sv
quad_encoder.sv
step_generator.sv
command_decoder.sv
motion_top.sv
tb_motion.sv

//--- step_generator.sv
`timescale 1ns/1ps
`include "motion_consts.svh"

module step_generator import motion_pkg::*; (
  input  logic   CLK,
  input  logic   resetn,
  input  logic   halt_n,
  input  logic   move_push,
  input  count_t move_duration,
  input  count_t move_increment,
  input  count_t move_incr_incr,
  input  logic   move_dir,
  input  div_t   clock_divisor,
  output logic   step,
  output logic   dir,
  output logic   buffer_dtr,
  output logic   move_done
);

  localparam count_t step_th = `STEP_THRESHOLD;
  localparam logic [`MOVE_BUFFER_BITS:0] buf_full = `MOVE_BUFFER_SIZE;

  // Move buffer storage
  count_t dur_mem    [`MOVE_BUFFER_SIZE];
  count_t inc_mem    [`MOVE_BUFFER_SIZE];
  count_t incinc_mem [`MOVE_BUFFER_SIZE];
  logic [`MOVE_BUFFER_SIZE-1:0] dir_mem;

  buf_idx_t wr_idx;
  buf_idx_t rd_idx;
  logic [`MOVE_BUFFER_BITS:0] fill;  // Entries held, 0 to 4

  logic   push_ok;
  logic   load;      // Idle with a move waiting
  logic   tick;
  logic   finish;    // Last tick of the current move
  logic   advance;   // Tick that feeds the DDA
  logic   over_th;
  logic   active;
  div_t   div_cnt;
  count_t tick_cnt;  // Ticks left in the move
  count_t incr_r;    // Ramping per tick increment
  count_t accum;
  count_t add_term;
  count_t sub_term;

  assign buffer_dtr = (fill != buf_full);
  assign push_ok    = move_push & buffer_dtr & halt_n;  // Halt wins over a push
  assign load       = !active && (fill != '0);
  assign tick       = active && (div_cnt == '0);
  assign finish     = tick && (tick_cnt == '0);
  assign advance    = tick & halt_n;

  // Buffer write side
  always_ff @(posedge CLK) begin
    if (push_ok) begin
      dur_mem[wr_idx]    <= move_duration;
      inc_mem[wr_idx]    <= move_increment;
      incinc_mem[wr_idx] <= move_incr_incr;
      dir_mem[wr_idx]    <= move_dir;
    end
  end

  // Sequencing and tick divider
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_idx    <= '0;
      rd_idx    <= '0;
      fill      <= '0;
      active    <= 1'b0;
      move_done <= 1'b0;
      dir       <= 1'b0;
      div_cnt   <= '0;
      tick_cnt  <= '0;
      incr_r    <= '0;
    end else if (!halt_n) begin
      rd_idx <= wr_idx;  // Drop everything queued
      fill   <= '0;
      active <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_idx <= wr_idx + 1'b1;
      end
      fill <= fill + {{`MOVE_BUFFER_BITS{1'b0}}, push_ok}
                   - {{`MOVE_BUFFER_BITS{1'b0}}, finish};
      if (load) begin
        tick_cnt <= dur_mem[rd_idx];
        incr_r   <= inc_mem[rd_idx];
        dir      <= dir_mem[rd_idx];
        div_cnt  <= clock_divisor;
        active   <= 1'b1;
      end else if (tick) begin
        div_cnt <= clock_divisor;  // Next tick in divisor+1 cycles
        incr_r  <= incr_r + incinc_mem[rd_idx];  // Ramp after the add
        if (finish) begin
          active    <= 1'b0;
          rd_idx    <= rd_idx + 1'b1;
          move_done <= ~move_done;
        end else begin
          tick_cnt <= tick_cnt - 64'sd1;
        end
      end else if (active) begin
        div_cnt <= div_cnt - 8'd1;
      end
    end
  end

  // DDA accumulator, survives a halt
  assign over_th  = (accum >= step_th);
  assign add_term = advance ? incr_r : '0;
  assign sub_term = over_th ? step_th : '0;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      accum <= '0;
      step  <= 1'b0;
    end else begin
      accum <= accum + add_term - sub_term;
      step  <= over_th;  // One pulse per threshold crossing
    end
  end

  // Decoder must hold moves back while full
  a_no_push_full: assert property (@(posedge CLK) disable iff (!resetn)
    move_push |-> buffer_dtr)
    else $error("move_push while buffer full");

  // Increment above threshold would merge pulses
  a_step_single: assert property (@(posedge CLK) disable iff (!resetn)
    step |=> !step)
    else $error("step high two cycles in a row");

endmodule

//--- tb_motion.sv
`timescale 1ns/1ps
`include "motion_consts.svh"

module tb_motion import motion_pkg::*;;

  localparam longint th = `STEP_THRESHOLD;
  localparam int max_cycles = 54 * 532 + 5 * 41 * 256 + 30000;  // Words, long moves, slack
  localparam int C_REPLY = 0;
  localparam int C_STEPS = 1;
  localparam int C_DONE  = 2;
  localparam int C_FAULT = 3;
  localparam int C_DTR   = 4;
  localparam int C_CFG   = 5;
  localparam int C_IDLE  = 6;

  logic CLK;
  logic resetn;
  logic sck;
  logic cs;
  logic copi;
  logic enc_a;
  logic enc_b;
  logic halt_n;
  logic cipo;
  logic step;
  logic dir;
  logic enable;
  logic [2:0] microsteps;
  logic [7:0] current;
  logic buffer_dtr;
  logic move_done;
  logic enc_fault;

  logic [7:0]  chk;       // One strobe per kind of check
  logic        quiet;     // No steps allowed
  logic        exp_dir;
  logic        exp_dtr;
  logic [11:0] exp_cfg;
  word_t       exp_reply;
  word_t       got_reply;
  word_t       r;
  int          exp_steps;
  int          exp_done;
  int          step_count = 0;
  int          done_count = 0;
  logic        done_q = 1'b0;
  int          cycle_count = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  integer      seed;
  longint      model_acc = 0;  // Reference DDA accumulator
  longint      enc_model = 0;  // Reference encoder position
  logic [1:0]  quad_pos = 2'd0;
  int          i;
  int          k;
  int          base;
  int          n;

  motion_top dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Pulse and toggle counters, plus the watchdog
  always @(posedge CLK) begin
    cycle_count++;
    if (step === 1'b1) step_count++;
    if (move_done !== done_q && move_done !== 1'bx) done_count++;
    done_q = move_done;
    if (cycle_count >= max_cycles) begin
      $display("Timeout after %0d cycles, the DUT never reached the expected state", cycle_count);
      $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
      $display("Some tests failed");
      $finish;
    end
  end

  a_reply: assert property (@(posedge CLK) chk[C_REPLY] |-> got_reply == exp_reply)
    else begin
      n_errors++;
      $display("Error at %0t: reply_data expected %h, got %h", $time, exp_reply, got_reply);
    end
  a_steps: assert property (@(posedge CLK) chk[C_STEPS] |-> step_count == exp_steps)
    else begin
      n_errors++;
      $display("Error at %0t: step count expected %0d, got %0d", $time, exp_steps, step_count);
    end
  a_done: assert property (@(posedge CLK) chk[C_DONE] |-> done_count == exp_done)
    else begin
      n_errors++;
      $display("Error at %0t: move_done toggles expected %0d, got %0d", $time, exp_done,
               done_count);
    end
  a_fault: assert property (@(posedge CLK) chk[C_FAULT] |-> enc_fault)
    else begin
      n_errors++;
      $display("Error at %0t: enc_fault expected 1, got %b", $time, enc_fault);
    end
  a_dtr: assert property (@(posedge CLK) chk[C_DTR] |-> buffer_dtr == exp_dtr)
    else begin
      n_errors++;
      $display("Error at %0t: buffer_dtr expected %b, got %b", $time, exp_dtr, buffer_dtr);
    end
  a_cfg: assert property (@(posedge CLK) chk[C_CFG] |-> {enable, microsteps, current} == exp_cfg)
    else begin
      n_errors++;
      $display("Error at %0t: {enable, microsteps, current} expected %h, got %h", $time,
               exp_cfg, {enable, microsteps, current});
    end
  a_idle: assert property (@(posedge CLK)
    chk[C_IDLE] |-> {step, dir, move_done, cipo, enc_fault, buffer_dtr} == 6'b000001)
    else begin
      n_errors++;
      $display("Error at %0t: {step,dir,move_done,cipo,enc_fault,buffer_dtr} expected %b, got %b",
               $time, 6'b000001, {step, dir, move_done, cipo, enc_fault, buffer_dtr});
    end
  a_step_dir: assert property (@(posedge CLK) disable iff (!resetn) step |-> dir == exp_dir)
    else begin
      n_errors++;
      $display("Error at %0t: dir expected %b, got %b", $time, exp_dir, dir);
    end
  a_quiet: assert property (@(posedge CLK) quiet |-> !step)
    else begin
      n_errors++;
      $display("Error at %0t: step expected 0, got %b", $time, step);
    end

  // One cycle strobe, seen by the assertion on the next rising edge
  task automatic check(input int which);
    chk[which] = 1'b1;
    n_checks++;
    @(negedge CLK);
    chk[which] = 1'b0;
  endtask

  // SPI mode 0 master, 8 CLK per bit, MSB first
  task automatic xfer(input word_t tx, output word_t rx);
    word_t sh;
    sh = tx;
    rx = '0;
    cs = 1'b0;
    repeat (4) @(negedge CLK);
    repeat (64) begin
      copi = sh[63];
      sh   = {sh[62:0], 1'b0};
      repeat (4) @(negedge CLK);
      rx  = {rx[62:0], cipo};  // Settled since the last falling sck
      sck = 1'b1;
      repeat (4) @(negedge CLK);
      sck = 1'b0;
    end
    repeat (8) @(negedge CLK);  // Word strobe lands inside the frame
    cs   = 1'b1;
    copi = 1'b0;
    repeat (8) @(negedge CLK);
  endtask

  // Header, duration, increment, ramp; reply of word three returned
  task automatic send_move(input logic d, input word_t dur, input word_t inc,
                           input word_t ramp, output word_t enc_reply);
    word_t dummy;
    xfer({`CMD_COORDINATED_STEP, 55'd0, d}, dummy);
    xfer(dur, dummy);
    xfer(inc, enc_reply);
    xfer(ramp, dummy);
  endtask

  task automatic wait_done(input int target);
    while (done_count < target) @(negedge CLK);
    repeat (8) @(negedge CLK);  // Last step trails the final tick
  endtask

  // Reference DDA over duration+1 ticks, add first then ramp
  function automatic int dda_steps(input longint dur, input longint inc, input longint ramp);
    longint t;
    int     cnt;
    cnt = 0;
    for (t = 0; t <= dur; t++) begin
      model_acc = model_acc + inc;
      inc       = inc + ramp;
      while (model_acc >= th) begin
        model_acc = model_acc - th;
        cnt++;
      end
    end
    return cnt;
  endfunction

  initial begin
    seed      = 32'he75d;
    resetn    = 1'b0;
    sck       = 1'b0;
    cs        = 1'b1;
    copi      = 1'b0;
    enc_a     = 1'b0;
    enc_b     = 1'b0;
    halt_n    = 1'b1;
    chk       = '0;
    quiet     = 1'b0;
    exp_dir   = 1'b0;
    exp_dtr   = 1'b1;
    exp_reply = '0;
    got_reply = '0;
    exp_steps = 0;
    exp_done  = 0;
    repeat (16) @(negedge CLK);
    resetn = 1'b1;
    @(negedge CLK);

    exp_cfg = {1'b0, 3'd2, 8'd140};  // Reset values
    check(C_IDLE);
    check(C_CFG);
    xfer({`CMD_MOTOR_ENABLE, 55'd0, 1'b1}, r);
    xfer({`CMD_MOTORCONFIG, 40'd0, 8'd200, 5'd0, 3'd5}, r);
    exp_cfg = {1'b1, 3'd5, 8'd200};
    check(C_CFG);

    xfer({`CMD_API_VERSION, 56'd0}, r);
    xfer(64'd0, got_reply);  // Version rides on the next word
    exp_reply = {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
    check(C_REPLY);

    xfer({`CMD_CLK_DIVISOR, 48'd0, 8'd3}, r);

    // Random walk on the encoder
    for (i = 0; i < 40; i++) begin
      if (($random(seed) & 1) != 0) begin
        quad_pos  = quad_pos + 2'd1;  // A leads
        enc_model = enc_model + 1;
      end else begin
        quad_pos  = quad_pos - 2'd1;
        enc_model = enc_model - 1;
      end
      enc_a = quad_pos[1] ^ quad_pos[0];
      enc_b = quad_pos[1];
      repeat (4) @(negedge CLK);
    end
    repeat (4) @(negedge CLK);
    n = dda_steps(2, 0, 0);
    send_move(1'b0, 64'd2, 64'd0, 64'd0, got_reply);
    exp_reply = enc_model;
    check(C_REPLY);
    wait_done(1);
    exp_done = 1;
    check(C_DONE);
    {enc_a, enc_b} = ~{enc_a, enc_b};  // Both lines at once
    repeat (6) @(negedge CLK);
    check(C_FAULT);

    // Flat move, one step per four ticks
    base = step_count;
    n = dda_steps(39, th / 4, 0);
    exp_steps = base + (39 + 1) / 4;
    send_move(1'b0, 64'd39, th / 4, 64'd0, r);
    wait_done(2);
    exp_done = 2;
    check(C_STEPS);
    check(C_DONE);

    // Ramped move, other direction
    exp_dir = 1'b1;
    base = step_count;
    exp_steps = base + dda_steps(31, th / 8, 64'h100_0000);
    send_move(1'b1, 64'd31, th / 8, 64'h100_0000, r);
    wait_done(3);
    exp_done = 3;
    check(C_STEPS);
    check(C_DONE);

    // Slow ticks so four moves pile up
    xfer({`CMD_CLK_DIVISOR, 48'd0, 8'd255}, r);
    exp_dir = 1'b0;
    base = step_count;
    n = 0;
    for (k = 0; k < 4; k++) begin
      n = n + dda_steps(40, th / 2, 0);
      send_move(1'b0, 64'd40, th / 2, 64'd0, r);
    end
    exp_dtr = 1'b0;
    check(C_DTR);
    send_move(1'b0, 64'd40, th / 2, 64'd0, r);  // Dropped
    wait_done(7);
    repeat (1100) @(negedge CLK);  // Four slow ticks, a queued fifth move would step
    exp_steps = base + n;
    exp_done  = 7;
    check(C_STEPS);
    check(C_DONE);
    exp_dtr = 1'b1;
    check(C_DTR);

    // Fill the buffer again and halt inside the first move
    exp_dir = 1'b1;
    for (k = 0; k < 4; k++) begin
      send_move(1'b1, 64'd40, th / 2, 64'd0, r);
    end
    exp_dtr = 1'b0;
    check(C_DTR);
    halt_n = 1'b0;
    repeat (4) @(negedge CLK);
    quiet = 1'b1;
    exp_dtr = 1'b1;
    check(C_DTR);
    repeat (4) @(negedge CLK);
    halt_n = 1'b1;
    repeat (2000) @(negedge CLK);
    check(C_DONE);  // Aborted move never completes
    quiet = 1'b0;

    repeat (4) @(negedge CLK);
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
